/* crossbar_fabric.sv */
`default_nettype none

`include "switch_consts.svh"

module crossbar_fabric (
    input  logic                                     clk,
    input  logic                                     rst,
    input  switch_pkg::cell_data_t [`SW_PORTS-1:0]   head_data,
    sched_if.fabric                                  fif,
    output switch_pkg::port_vec_t                    xbar_valid,
    output switch_pkg::cell_data_t [`SW_PORTS-1:0]   xbar_data,
    output switch_pkg::port_idx_t  [`SW_PORTS-1:0]   xbar_src
);
    import switch_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            xbar_valid <= '0;
        end else begin
            xbar_valid <= fif.out_grant;
        end
    end

    // mux per output, selected by the matched input
    always_ff @(posedge clk) begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            if (fif.out_grant[o]) begin
                xbar_data[o] <= head_data[fif.out_src[o]];
                xbar_src[o]  <= fif.out_src[o];
            end
        end
    end

endmodule

`default_nettype wire

/* crossbar_sched.sv */
`default_nettype none

`include "switch_consts.svh"

module crossbar_sched (
    input  logic   clk,
    input  logic   rst,
    sched_if.sched sif
);
    import switch_pkg::*;

    port_idx_t     grant_ptr [`SW_PORTS];
    port_idx_t     accept_ptr [`SW_PORTS];
    accept_state_e acc_state [`SW_PORTS];

    // requests seen by each output, bit per input
    port_vec_t     req_col [`SW_PORTS];
    // grant_to[o][i] and its transpose grant_in[i][o]
    port_vec_t     grant_to [`SW_PORTS];
    port_vec_t     grant_in [`SW_PORTS];

    // first set bit at or after ptr, wrapping
    function automatic port_idx_t rr_pick(input port_vec_t req, input port_idx_t ptr);
        port_idx_t idx;
        port_idx_t pick;
        logic      found;
        pick  = ptr;
        found = 1'b0;
        for (int k = 0; k < `SW_PORTS; k++) begin
            idx = ptr + port_idx_t'(k);
            if (!found && req[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // grant stage, only outputs holding a credit
    always_comb begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            grant_to[o] = '0;
            for (int i = 0; i < `SW_PORTS; i++) begin
                req_col[o][i] = sif.voq_nonempty[i][o] && sif.out_ready[o];
            end
            if (|req_col[o]) begin
                grant_to[o][rr_pick(req_col[o], grant_ptr[o])] = 1'b1;
            end
        end
    end

    // accept stage
    always_comb begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                grant_in[i][o] = grant_to[o][i];
            end
            sif.accept_valid[i] = |grant_in[i];
            sif.accept_dest[i]  = rr_pick(grant_in[i], accept_ptr[i]);
            acc_state[i]        = sif.accept_valid[i] ? ACC_MATCHED : ACC_IDLE;
        end
    end

    always_comb begin
        sif.out_grant = '0;
        for (int o = 0; o < `SW_PORTS; o++) begin
            sif.out_src[o] = '0;
        end
        for (int i = 0; i < `SW_PORTS; i++) begin
            if (sif.accept_valid[i]) begin
                sif.out_grant[sif.accept_dest[i]] = 1'b1;
                sif.out_src[sif.accept_dest[i]]   = port_idx_t'(i);
            end
        end
    end

    // pointers go one past the matched partner
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                grant_ptr[p]  <= '0;
                accept_ptr[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                if (sif.out_grant[p]) begin
                    grant_ptr[p] <= sif.out_src[p] + port_idx_t'(1);
                end
                if (acc_state[p] == ACC_MATCHED) begin
                    accept_ptr[p] <= sif.accept_dest[p] + port_idx_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* output_port.sv */
`default_nettype none

`include "switch_consts.svh"

module output_port (
    input  logic                                     clk,
    input  logic                                     rst,
    input  switch_pkg::port_vec_t                    xbar_valid,
    input  switch_pkg::cell_data_t [`SW_PORTS-1:0]   xbar_data,
    input  switch_pkg::port_idx_t  [`SW_PORTS-1:0]   xbar_src,
    input  switch_pkg::port_vec_t                    out_credit,
    sched_if.out                                     oif,
    output switch_pkg::port_vec_t                    out_valid,
    output switch_pkg::cell_data_t [`SW_PORTS-1:0]   out_data,
    output switch_pkg::port_idx_t  [`SW_PORTS-1:0]   out_src
);
    import switch_pkg::*;

    credit_cnt_t credit [`SW_PORTS];

    // a grant spends the credit, downstream pulses refill
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                credit[o] <= credit_cnt_t'(`SW_OUT_CREDITS);
            end
        end else begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                credit[o] <= credit[o] + credit_cnt_t'(out_credit[o])
                             - credit_cnt_t'(oif.out_grant[o]);
            end
        end
    end

    always_comb begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            oif.out_ready[o] = (credit[o] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= xbar_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < `SW_PORTS; o++) begin
            if (xbar_valid[o]) begin
                out_data[o] <= xbar_data[o];
                out_src[o]  <= xbar_src[o];
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module switch_tb -o switch_sim
./obj_dir/switch_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
grep -q "=== PASS ===" sim.log
echo "simulation passed"

/* sched_if.sv */
`default_nettype none

`include "switch_consts.svh"

interface sched_if;
    import switch_pkg::*;

    // [input][dest]
    port_vec_t voq_nonempty [`SW_PORTS];
    port_vec_t out_ready;

    // per input
    port_vec_t accept_valid;
    port_idx_t accept_dest [`SW_PORTS];

    // per output
    port_vec_t out_grant;
    port_idx_t out_src [`SW_PORTS];

    modport voq (
        output voq_nonempty,
        input  accept_valid,
        input  accept_dest
    );

    modport sched (
        input  voq_nonempty,
        input  out_ready,
        output accept_valid,
        output accept_dest,
        output out_grant,
        output out_src
    );

    modport fabric (
        input out_grant,
        input out_src
    );

    modport out (
        output out_ready,
        input  out_grant
    );

endinterface

`default_nettype wire

/* switch_consts.svh */
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// number of input and output ports
`define SW_PORTS 4

// cell payload width
`define SW_DATA_W 16

// slots per voq, also the upstream credits per voq
`define SW_VOQ_DEPTH 4

// downstream credits per output after reset
`define SW_OUT_CREDITS 2

`endif

/* switch_pkg.sv */
`default_nettype none

`include "switch_consts.svh"

package switch_pkg;

    typedef logic [$clog2(`SW_PORTS)-1:0] port_idx_t;

    // one bit per port
    typedef logic [`SW_PORTS-1:0] port_vec_t;

    typedef logic [`SW_DATA_W-1:0] cell_data_t;

    // wide enough for a full voq count
    typedef logic [$clog2(`SW_VOQ_DEPTH):0] credit_cnt_t;

    typedef enum logic {
        ACC_IDLE,
        ACC_MATCHED
    } accept_state_e;

endpackage

`default_nettype wire

/* switch_tb.sv */
`default_nettype none

`include "switch_consts.svh"

module switch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import switch_pkg::*;

    localparam int PAIRS       = `SW_PORTS * `SW_PORTS;
    localparam int TOTAL_CELLS = 114;
    // one round robin turn of the other inputs
    localparam int FAIR_LIMIT  = `SW_PORTS - 1;

    logic clk;
    logic rst;

    port_vec_t                  in_valid   = '0;
    port_idx_t  [`SW_PORTS-1:0] in_dest    = '0;
    cell_data_t [`SW_PORTS-1:0] in_data    = '0;
    port_vec_t                  out_credit = '0;
    port_vec_t                  in_credit;
    port_idx_t  [`SW_PORTS-1:0] in_credit_dest;
    port_vec_t                  out_valid;
    cell_data_t [`SW_PORTS-1:0] out_data;
    port_idx_t  [`SW_PORTS-1:0] out_src;

    int seed     = 27;
    int cycle    = 0;
    int errors   = 0;
    int err_mark = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int rx_mark;

    // per pair, index src * ports + dest
    cell_data_t exp_q [PAIRS][$];
    int         inj_q [PAIRS][$];
    int         rx_idx [PAIRS];
    int         sent_cnt [PAIRS];
    int         ret_cnt [PAIRS];

    // downstream side
    int         rx_cnt [`SW_PORTS];
    int         dn_ret [`SW_PORTS];
    port_vec_t  hold = '0;
    bit         ret_ok [64];

    port_idx_t  plan_q [`SW_PORTS][$];
    int         wait_cnt [`SW_PORTS];
    bit         fair_on = 1'b0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock_gen (.clk(clk), .rst(rst));

    switch_top u_switch_top (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_dest        (in_dest),
        .in_data        (in_data),
        .in_credit      (in_credit),
        .in_credit_dest (in_credit_dest),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_src        (out_src),
        .out_credit     (out_credit)
    );

    task automatic check_data(input string name, input cell_data_t got, input cell_data_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_src(input string name, input port_idx_t got, input port_idx_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_credit(input string name, input credit_cnt_t got,
                                input credit_cnt_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input port_vec_t got, input port_vec_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int pending_cells(input int p);
        return exp_q[p].size() - rx_idx[p];
    endfunction

    // next cell in arrival order for this pair
    function automatic cell_data_t expected_cell(input port_idx_t src, input port_idx_t dest);
        int p;
        p = int'(src) * `SW_PORTS + int'(dest);
        rx_idx[p]++;
        return exp_q[p][rx_idx[p] - 1];
    endfunction

    function automatic credit_cnt_t up_credit(input int p);
        return credit_cnt_t'(`SW_VOQ_DEPTH - (sent_cnt[p] - ret_cnt[p]));
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // payload is {src, dest, sequence}
    task automatic send_one(input port_idx_t s, input port_idx_t d);
        int         p;
        cell_data_t c;
        p = int'(s) * `SW_PORTS + int'(d);
        c = cell_data_t'({s, d, 12'(sent_cnt[p])});
        in_valid[s] <= 1'b1;
        in_dest[s]  <= d;
        in_data[s]  <= c;
        exp_q[p].push_back(c);
        inj_q[p].push_back(cycle + 1);
        sent_cnt[p]++;
    endtask

    task automatic run_traffic();
        int left;
        int p;
        left = 1;
        while (left != 0) begin
            @(posedge clk);
            left = 0;
            for (int s = 0; s < `SW_PORTS; s++) begin
                in_valid[s] <= 1'b0;
                if (plan_q[s].size() != 0) begin
                    p = s * `SW_PORTS + int'(plan_q[s][0]);
                    if (sent_cnt[p] - ret_cnt[p] < `SW_VOQ_DEPTH) begin
                        send_one(port_idx_t'(s), plan_q[s].pop_front());
                    end
                end
                left += plan_q[s].size();
            end
        end
        @(posedge clk);
        in_valid <= '0;
    endtask

    task automatic wait_drain();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(negedge clk);
            busy = 0;
            for (int p = 0; p < PAIRS; p++) begin
                busy += pending_cells(p);
            end
            for (int o = 0; o < `SW_PORTS; o++) begin
                busy += rx_cnt[o] - dn_ret[o];
            end
        end
        // last credit pulses still travelling
        repeat (4) @(negedge clk);
    endtask

    task automatic check_conservation();
        int p;
        for (int s = 0; s < `SW_PORTS; s++) begin
            for (int d = 0; d < `SW_PORTS; d++) begin
                p = s * `SW_PORTS + d;
                if (ret_cnt[p] != sent_cnt[p]) begin
                    $display("input %0d dest %0d returned %0d credits for %0d cells",
                             s, d, ret_cnt[p], sent_cnt[p]);
                    errors++;
                end
                check_credit($sformatf("up_credit[%0d][%0d]", s, d), up_credit(p),
                             credit_cnt_t'(`SW_VOQ_DEPTH));
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            $display("test %s passed", name);
            pass_cnt++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_mark);
            fail_cnt++;
        end
        err_mark = errors;
    endtask

    always @(negedge clk) begin : monitor
        port_idx_t s;
        port_idx_t d;
        int        p;
        if (!rst) begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                if (out_valid[o]) begin
                    s = out_data[o][`SW_DATA_W-1 -: $bits(port_idx_t)];
                    p = int'(s) * `SW_PORTS + o;
                    check_src($sformatf("out_src[%0d]", o), out_src[o], s);
                    if (pending_cells(p) <= 0) begin
                        $display("output %0d delivered a cell that was never sent", o);
                        errors++;
                    end else begin
                        if (cycle - inj_q[p][rx_idx[p]] < 3) begin
                            $display("cell from input %0d reached output %0d too early", s, o);
                            errors++;
                        end
                        check_data($sformatf("out_data[%0d]", o), out_data[o],
                                   expected_cell(s, port_idx_t'(o)));
                    end
                    rx_cnt[o]++;
                end
            end
            if (fair_on && out_valid[0]) begin
                s = out_data[0][`SW_DATA_W-1 -: $bits(port_idx_t)];
                for (int k = 0; k < `SW_PORTS; k++) begin
                    if (k != int'(s) && pending_cells(k * `SW_PORTS) > 0) begin
                        wait_cnt[k]++;
                        if (wait_cnt[k] > FAIR_LIMIT) begin
                            $display("input %0d waited behind %0d cells of other inputs",
                                     k, wait_cnt[k]);
                            errors++;
                        end
                    end
                end
                wait_cnt[s] = 0;
            end
            for (int k = 0; k < `SW_PORTS; k++) begin
                if (pending_cells(k * `SW_PORTS) == 0) begin
                    wait_cnt[k] = 0;
                end
            end
            for (int i = 0; i < `SW_PORTS; i++) begin
                if (in_credit[i]) begin
                    d = in_credit_dest[i];
                    p = i * `SW_PORTS + int'(d);
                    if (ret_cnt[p] >= sent_cnt[p]) begin
                        $display("input %0d got a credit back for dest %0d it never spent",
                                 i, d);
                        errors++;
                    end
                    ret_cnt[p]++;
                end
            end
        end
    end

    // downstream receiver returns credits after a random gap
    always @(posedge clk) begin : credit_return
        port_vec_t pulse;
        pulse = '0;
        if (!rst) begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                if (!hold[o] && rx_cnt[o] > dn_ret[o] && ret_ok[(cycle + 5 * o) % 64]) begin
                    pulse[o] = 1'b1;
                    dn_ret[o]++;
                end
            end
        end
        out_credit <= pulse;
    end

    initial begin
        repeat (TOTAL_CELLS * 200) @(posedge clk);
        $display("simulation timed out before all cells were delivered");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        for (int k = 0; k < 64; k++) begin
            ret_ok[k] = ($random(seed) & 1) != 0;
        end
        @(negedge rst);
        repeat (8) begin
            @(negedge clk);
            check_flags("out_valid", out_valid, '0);
            check_flags("in_credit", in_credit, '0);
        end
        end_test("reset state");

        for (int s = 0; s < `SW_PORTS; s++) begin
            plan_q[s].push_back(port_idx_t'(s + 1));
        end
        run_traffic();
        wait_drain();
        end_test("single cell routing");

        // every input onto output 0
        fair_on = 1'b1;
        for (int s = 0; s < `SW_PORTS; s++) begin
            repeat (6) plan_q[s].push_back(port_idx_t'(0));
        end
        run_traffic();
        wait_drain();
        fair_on = 1'b0;
        end_test("per pair ordering under contention");

        check_conservation();
        end_test("upstream credit conservation");

        hold[2] = 1'b1;
        rx_mark = rx_cnt[2];
        for (int s = 0; s < 2; s++) begin
            repeat (3) plan_q[s].push_back(port_idx_t'(2));
        end
        run_traffic();
        repeat (20) @(negedge clk);
        check_credit("held_out_cells", credit_cnt_t'(rx_cnt[2] - rx_mark),
                     credit_cnt_t'(`SW_OUT_CREDITS));
        hold[2] = 1'b0;
        wait_drain();
        end_test("downstream back-pressure");

        for (int s = 0; s < `SW_PORTS; s++) begin
            repeat (20) plan_q[s].push_back(port_idx_t'($random(seed)));
        end
        run_traffic();
        wait_drain();
        check_conservation();
        end_test("random full traffic");

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* switch_top.sv */
`default_nettype none

`include "switch_consts.svh"

module switch_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  switch_pkg::port_vec_t                    in_valid,
    input  switch_pkg::port_idx_t  [`SW_PORTS-1:0]   in_dest,
    input  switch_pkg::cell_data_t [`SW_PORTS-1:0]   in_data,
    output switch_pkg::port_vec_t                    in_credit,
    output switch_pkg::port_idx_t  [`SW_PORTS-1:0]   in_credit_dest,
    output switch_pkg::port_vec_t                    out_valid,
    output switch_pkg::cell_data_t [`SW_PORTS-1:0]   out_data,
    output switch_pkg::port_idx_t  [`SW_PORTS-1:0]   out_src,
    input  switch_pkg::port_vec_t                    out_credit
);
    import switch_pkg::*;

    cell_data_t [`SW_PORTS-1:0] head_data;
    port_vec_t                  xbar_valid;
    cell_data_t [`SW_PORTS-1:0] xbar_data;
    port_idx_t  [`SW_PORTS-1:0] xbar_src;

    sched_if sif ();

    voq_bank u_voq_bank (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_dest        (in_dest),
        .in_data        (in_data),
        .in_credit      (in_credit),
        .in_credit_dest (in_credit_dest),
        .head_data      (head_data),
        .sched          (sif)
    );

    crossbar_sched u_crossbar_sched (
        .clk (clk),
        .rst (rst),
        .sif (sif)
    );

    crossbar_fabric u_crossbar_fabric (
        .clk        (clk),
        .rst        (rst),
        .head_data  (head_data),
        .fif        (sif),
        .xbar_valid (xbar_valid),
        .xbar_data  (xbar_data),
        .xbar_src   (xbar_src)
    );

    output_port u_output_port (
        .clk        (clk),
        .rst        (rst),
        .xbar_valid (xbar_valid),
        .xbar_data  (xbar_data),
        .xbar_src   (xbar_src),
        .out_credit (out_credit),
        .oif        (sif),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_src    (out_src)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
switch_pkg.sv
sched_if.sv
voq_bank.sv
crossbar_sched.sv
crossbar_fabric.sv
output_port.sv
switch_top.sv
tb_clock_gen.sv
switch_tb.sv

/* voq_bank.sv */
`default_nettype none

`include "switch_consts.svh"

module voq_bank (
    input  logic                                     clk,
    input  logic                                     rst,
    input  switch_pkg::port_vec_t                    in_valid,
    input  switch_pkg::port_idx_t  [`SW_PORTS-1:0]   in_dest,
    input  switch_pkg::cell_data_t [`SW_PORTS-1:0]   in_data,
    output switch_pkg::port_vec_t                    in_credit,
    output switch_pkg::port_idx_t  [`SW_PORTS-1:0]   in_credit_dest,
    output switch_pkg::cell_data_t [`SW_PORTS-1:0]   head_data,
    sched_if.voq                                     sched
);
    import switch_pkg::*;

    localparam int PTR_W = $clog2(`SW_VOQ_DEPTH);

    cell_data_t     mem [`SW_PORTS][`SW_PORTS][`SW_VOQ_DEPTH];
    logic [PTR_W-1:0] head_ptr [`SW_PORTS][`SW_PORTS];
    logic [PTR_W-1:0] tail_ptr [`SW_PORTS][`SW_PORTS];
    credit_cnt_t    fill [`SW_PORTS][`SW_PORTS];

    // [input][dest] write and read strobes
    port_vec_t      wr_hit [`SW_PORTS];
    port_vec_t      rd_hit [`SW_PORTS];

    always_comb begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            for (int d = 0; d < `SW_PORTS; d++) begin
                wr_hit[i][d] = in_valid[i] && (in_dest[i] == port_idx_t'(d));
                rd_hit[i][d] = sched.accept_valid[i] && (sched.accept_dest[i] == port_idx_t'(d));
                sched.voq_nonempty[i][d] = (fill[i][d] != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SW_PORTS; i++) begin
                for (int d = 0; d < `SW_PORTS; d++) begin
                    head_ptr[i][d] <= '0;
                    tail_ptr[i][d] <= '0;
                    fill[i][d]     <= '0;
                end
            end
        end else begin
            for (int i = 0; i < `SW_PORTS; i++) begin
                for (int d = 0; d < `SW_PORTS; d++) begin
                    if (wr_hit[i][d]) begin
                        tail_ptr[i][d] <= tail_ptr[i][d] + PTR_W'(1);
                    end
                    if (rd_hit[i][d]) begin
                        head_ptr[i][d] <= head_ptr[i][d] + PTR_W'(1);
                    end
                    fill[i][d] <= fill[i][d] + credit_cnt_t'(wr_hit[i][d])
                                  - credit_cnt_t'(rd_hit[i][d]);
                end
            end
        end
    end

    // upstream credit keeps writes off a full voq
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            for (int d = 0; d < `SW_PORTS; d++) begin
                if (wr_hit[i][d]) begin
                    mem[i][d][tail_ptr[i][d]] <= in_data[i];
                end
            end
        end
    end

    // head of the accepted voq, read in the accept cycle
    always_comb begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            head_data[i] = mem[i][sched.accept_dest[i]]
                              [head_ptr[i][sched.accept_dest[i]]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_credit <= '0;
        end else begin
            in_credit <= sched.accept_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            in_credit_dest[i] <= sched.accept_dest[i];
        end
    end

endmodule

`default_nettype wire
